/* Bender.yml */
package:
  name: quickq

sources:
  - verilog/pq_pkg.sv
  - verilog/pq_ctrl.sv
  - verilog/pq_cell.sv
  - verilog/quickq.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/quickq_tb.sv

/* quickq.f */
+incdir+include
verilog/pq_pkg.sv
verilog/pq_ctrl.sv
verilog/pq_cell.sv
verilog/quickq.sv
tests/quickq_tb.sv

/* include/quickq_tb_ref.svh */
`ifndef QUICKQ_TB_REF_SVH
`define QUICKQ_TB_REF_SVH

// --------------------------------------------------------------------------
// Reference model of the priority queue
// --------------------------------------------------------------------------

// Expected DUT outputs after one edge
typedef struct packed {
    logic [KEY_W-1:0] key;
    logic [VAL_W-1:0] val;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             empty;
} expect_t;

// Sorted pairs with the head at index 0
logic [KEY_W-1:0] model_key [CAPACITY];
logic [VAL_W-1:0] model_val [CAPACITY];
int               model_count = 0;

// Insert behind every stored key that is equal or smaller
function automatic void model_insert(input logic [KEY_W-1:0] key,
                                     input logic [VAL_W-1:0] val);
    int pos;
    pos = model_count;
    for (int i = 0; i < model_count; i++) begin
        if (model_key[i] > key && pos == model_count) begin
            pos = i;
        end
    end
    // Open a gap at pos
    for (int i = model_count; i > pos; i--) begin
        model_key[i] = model_key[i-1];
        model_val[i] = model_val[i-1];
    end
    model_key[pos] = key;
    model_val[pos] = val;
    model_count++;
endfunction

// Drop the head and move the rest up one place
function automatic void model_remove();
    for (int i = 0; i < model_count - 1; i++) begin
        model_key[i] = model_key[i+1];
        model_val[i] = model_val[i+1];
    end
    model_count--;
endfunction

// Applies one clock edge and returns what the outputs should show after it
function automatic expect_t ref_step(input logic             rst,
                                     input logic             enq,
                                     input logic             deq,
                                     input logic [KEY_W-1:0] key,
                                     input logic [VAL_W-1:0] val);
    expect_t e;
    pq_op_e  op;
    // Requests that cannot be served decode to NOP
    op = PQ_NOP;
    if (!rst) begin
        if (enq && deq) begin
            // Nothing to remove from an empty queue
            if (model_count == 0) begin
                op = PQ_ENQ;
            end else begin
                op = PQ_REPL;
            end
        end else if (enq && model_count < CAPACITY) begin
            op = PQ_ENQ;
        end else if (deq && model_count != 0) begin
            op = PQ_DEQ;
        end
    end
    if (rst) begin
        model_count = 0;
    end
    case (op)
        PQ_ENQ: begin
            model_insert(key, val);
        end
        PQ_DEQ: begin
            model_remove();
        end
        PQ_REPL: begin
            // Head leaves first so the new pair sorts among the rest
            model_remove();
            model_insert(key, val);
        end
        default: begin
            // NOP leaves the model as it is
        end
    endcase
    e.key   = model_key[0];
    e.val   = model_val[0];
    e.count = CNT_W'(model_count);
    e.full  = (model_count == CAPACITY);
    e.empty = (model_count == 0);
    return e;
endfunction

// --------------------------------------------------------------------------
// Compare tasks
// --------------------------------------------------------------------------

task automatic compare_head(input string            name,
                            input logic [KEY_W-1:0] exp_key,
                            input logic [VAL_W-1:0] exp_val,
                            input logic [KEY_W-1:0] act_key,
                            input logic [VAL_W-1:0] act_val);
    if (act_key !== exp_key || act_val !== exp_val) begin
        $display("** Error [%s] head: expected key %0d val %0d, actual key %0d val %0d",
                 name, exp_key, exp_val, act_key, act_val);
        error_count++;
        abort_run("Head pair does not match the reference model");
    end
endtask

task automatic compare_count(input string            name,
                             input logic [CNT_W-1:0] exp_count,
                             input logic [CNT_W-1:0] act_count);
    if (act_count !== exp_count) begin
        $display("** Error [%s] count: expected %0d, actual %0d",
                 name, exp_count, act_count);
        error_count++;
        abort_run("Occupancy count does not match the reference model");
    end
endtask

task automatic compare_flags(input string name,
                             input logic  exp_full,
                             input logic  exp_empty,
                             input logic  act_full,
                             input logic  act_empty);
    if (act_full !== exp_full || act_empty !== exp_empty) begin
        $display("** Error [%s] flags: expected full %b empty %b, actual full %b empty %b",
                 name, exp_full, exp_empty, act_full, act_empty);
        error_count++;
        abort_run("Full or empty flag does not match the reference model");
    end
endtask

`endif

/* tests/quickq_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module quickq_tb import pq_pkg::*;;

    localparam int KEY_W      = 8;
    localparam int VAL_W      = 8;
    localparam int CAPACITY   = 8;
    localparam int CNT_W      = $clog2(CAPACITY + 1);
    localparam int CLK_PERIOD = 4;

    // Run length, upper bound of the directed part
    localparam int N_DIRECTED = 150;
    localparam int N_RANDOM   = 400;
    localparam int TIMEOUT_NS = (N_DIRECTED + N_RANDOM + 50) * CLK_PERIOD * 2;
    localparam int SEED       = 32'h9d3e;

    logic             clk;
    logic             reset_i;
    logic             enq_i;
    logic             deq_i;
    logic [KEY_W-1:0] key_i;
    logic [VAL_W-1:0] val_i;
    logic [KEY_W-1:0] head_key_o;
    logic [VAL_W-1:0] head_val_o;
    logic [CNT_W-1:0] count_o;
    logic             full_o;
    logic             empty_o;

    // Name of the running section, and the one that goes with the driven request
    string            current_test;
    string            req_name;
    integer           seed;
    int               error_count = 0;

    task automatic abort_run(input string reason);
        $display("Test FAILED");
        $fatal(1, "%s", reason);
    endtask

`include "quickq_tb_ref.svh"

    quickq #(
        .KEY_W    (KEY_W),
        .VAL_W    (VAL_W),
        .CAPACITY (CAPACITY)
    ) i_quickq (
        .clk        (clk),
        .reset_i    (reset_i),
        .enq_i      (enq_i),
        .deq_i      (deq_i),
        .key_i      (key_i),
        .val_i      (val_i),
        .head_key_o (head_key_o),
        .head_val_o (head_val_o),
        .count_o    (count_o),
        .full_o     (full_o),
        .empty_o    (empty_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // Request drivers
    // ----------------------------------------------------------------------

    // Inputs change 1 ns after the edge, sampled at the next one
    task automatic apply_op(input logic e, input logic d,
                            input logic [KEY_W-1:0] k, input logic [VAL_W-1:0] v);
        @(posedge clk);
        #1;
        enq_i    = e;
        deq_i    = d;
        key_i    = k;
        val_i    = v;
        req_name = current_test;
    endtask

    task automatic push(input logic [KEY_W-1:0] k, input logic [VAL_W-1:0] v);
        apply_op(1'b1, 1'b0, k, v);
    endtask

    task automatic pop();
        apply_op(1'b0, 1'b1, '0, '0);
    endtask

    task automatic push_pop(input logic [KEY_W-1:0] k, input logic [VAL_W-1:0] v);
        apply_op(1'b1, 1'b1, k, v);
    endtask

    task automatic idle();
        apply_op(1'b0, 1'b0, '0, '0);
    endtask

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------

    initial begin : stimulus
        logic [31:0] r;
        logic        e;
        seed         = SEED;
        reset_i      = 1'b1;
        enq_i        = 1'b0;
        deq_i        = 1'b0;
        key_i        = '0;
        val_i        = '0;
        current_test = "reset";
        req_name     = "reset";
        repeat (3) @(posedge clk);
        #1;
        reset_i = 1'b0;
        idle();

        // Descending keys, every insert lands at the head
        current_test = "sorted_desc";
        for (int i = 0; i < CAPACITY; i++) begin
            push(KEY_W'(80 - 10 * i), VAL_W'(i));
        end
        repeat (CAPACITY) pop();

        // Ascending keys, every insert lands at the tail
        current_test = "sorted_asc";
        for (int i = 0; i < CAPACITY; i++) begin
            push(KEY_W'(10 + 10 * i), VAL_W'(i));
        end
        repeat (CAPACITY) pop();

        current_test = "sorted_mixed";
        push(8'd45, 8'd0);
        push(8'd12, 8'd1);
        push(8'd99, 8'd2);
        push(8'd3, 8'd3);
        push(8'd77, 8'd4);
        push(8'd250, 8'd5);
        push(8'd0, 8'd6);
        push(8'd60, 8'd7);
        repeat (CAPACITY) pop();

        // Equal keys leave in arrival order
        current_test = "ties_enq";
        push(8'd5, 8'd1);
        push(8'd5, 8'd2);
        push(8'd5, 8'd3);
        push(8'd2, 8'd4);
        push(8'd5, 8'd5);
        repeat (5) pop();

        current_test = "ties_repl";
        push(8'd9, 8'd1);
        push(8'd9, 8'd2);
        push_pop(8'd9, 8'd3);
        push_pop(8'd9, 8'd4);
        push_pop(8'd4, 8'd5);
        repeat (2) pop();

        // Enqueue on a full queue is dropped
        current_test = "full_enq";
        for (int i = 0; i < CAPACITY; i++) begin
            push(KEY_W'(30 + i), VAL_W'(i));
        end
        push(8'd1, 8'd99);
        repeat (CAPACITY) pop();

        current_test = "empty_deq";
        pop();
        pop();

        // Both requests on an empty queue act as an enqueue
        current_test = "empty_both";
        push_pop(8'd17, 8'd33);
        pop();

        // Replace on a full queue with equal, smaller and larger keys
        current_test = "repl_full";
        for (int i = 0; i < CAPACITY; i++) begin
            push(8'd40, VAL_W'(i));
        end
        push_pop(8'd40, 8'd8);
        push_pop(8'd10, 8'd9);
        push_pop(8'd250, 8'd10);
        repeat (CAPACITY) pop();

        // Back to back random requests, few distinct keys
        current_test = "random";
        for (int i = 0; i < N_RANDOM; i++) begin
            r = $random(seed);
            // Fill bias in the first half, drain bias in the second
            e = (i < N_RANDOM / 2) ? (r[1:0] != 2'b00) : (r[1:0] == 2'b00);
            apply_op(e, r[2], KEY_W'(r[4:3]), VAL_W'(i));
        end

        // Let the last compare finish
        current_test = "drain";
        idle();
        idle();
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // ----------------------------------------------------------------------
    // Compare against the reference model
    // ----------------------------------------------------------------------

    initial begin : compare_proc
        expect_t          exp;
        logic             s_rst;
        logic             s_enq;
        logic             s_deq;
        logic [KEY_W-1:0] s_key;
        logic [VAL_W-1:0] s_val;
        string            s_name;
        forever begin
            // Capture what the DUT samples at this edge
            @(posedge clk);
            s_rst  = reset_i;
            s_enq  = enq_i;
            s_deq  = deq_i;
            s_key  = key_i;
            s_val  = val_i;
            s_name = req_name;
            exp    = ref_step(s_rst, s_enq, s_deq, s_key, s_val);
            // Registered outputs are settled half a period later
            @(negedge clk);
            if (!exp.empty) begin
                compare_head(s_name, exp.key, exp.val, head_key_o, head_val_o);
            end
            compare_count(s_name, exp.count, count_o);
            compare_flags(s_name, exp.full, exp.empty, full_o, empty_o);
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        abort_run("Timeout: the run went on longer than all tests should take");
    end

endmodule : quickq_tb

`default_nettype wire

/* verilog/pq_cell.sv */
`timescale 1ns/1ps
`default_nettype none

// --------------------------------------------------------------------------
// One slot of the sorted shift-register array
// --------------------------------------------------------------------------

// Left neighbor is closer to the head, right neighbor closer to the tail
module pq_cell import pq_pkg::*; #(
    parameter int KEY_W   = 8,
    parameter int VAL_W   = 8,
    // Set only for slot 0, which takes the new pair when the head is replaced
    parameter bit IS_HEAD = 1'b0
) (
    input  logic             clk,
    input  logic             reset_i,
    // Operation for this cycle, already gated by the controller
    input  pq_op_e           op_i,
    // Pair offered by the requester
    input  logic [KEY_W-1:0] new_key_i,
    input  logic [VAL_W-1:0] new_val_i,
    // Left neighbor contents and its insert flag
    input  logic [KEY_W-1:0] left_key_i,
    input  logic [VAL_W-1:0] left_val_i,
    input  logic             left_valid_i,
    input  logic             left_ins_before_i,
    // Right neighbor contents and its shift-left flag
    input  logic [KEY_W-1:0] right_key_i,
    input  logic [VAL_W-1:0] right_val_i,
    input  logic             right_valid_i,
    input  logic             right_take_right_i,
    // Own slot, seen by both neighbors
    output logic [KEY_W-1:0] key_o,
    output logic [VAL_W-1:0] val_o,
    output logic             valid_o,
    // To the right neighbor: new pair belongs at or before this slot
    output logic             ins_before_o,
    // To the left neighbor: this pair moves left on replace
    output logic             take_right_o
);

    // Stored pair, valid bit is the only control state
    logic [KEY_W-1:0] key_q;
    logic [VAL_W-1:0] val_q;
    logic             valid_q;

    // Next slot contents
    logic [KEY_W-1:0] key_d;
    logic [VAL_W-1:0] val_d;
    logic             valid_d;

    // Local compare results
    logic             ins_before;
    logic             take_right;

    // ----------------------------------------------------------------------
    // Key compare
    // ----------------------------------------------------------------------

    // Strict less-than keeps equal keys in arrival order,
    // a new key lands behind all stored keys that equal it
    assign ins_before = !valid_q || (new_key_i < key_q);

    // Pairs with key <= new key sit in front of the new pair after replace
    assign take_right = valid_q && (key_q <= new_key_i);

    // ----------------------------------------------------------------------
    // Neighbor select
    // ----------------------------------------------------------------------

    always_comb begin
        key_d   = key_q;
        val_d   = val_q;
        valid_d = valid_q;
        case (op_i)
            PQ_ENQ: begin
                if (ins_before) begin
                    if (left_ins_before_i) begin
                        // Insert point is further left, shift right by one
                        key_d   = left_key_i;
                        val_d   = left_val_i;
                        valid_d = left_valid_i;
                    end else begin
                        // First slot where the new key fits
                        key_d   = new_key_i;
                        val_d   = new_val_i;
                        valid_d = 1'b1;
                    end
                end
            end
            PQ_DEQ: begin
                // Whole array moves toward the head
                key_d   = right_key_i;
                val_d   = right_val_i;
                valid_d = right_valid_i;
            end
            PQ_REPL: begin
                if (right_take_right_i) begin
                    // Smaller pairs move left into the gap of the old head
                    key_d   = right_key_i;
                    val_d   = right_val_i;
                    valid_d = right_valid_i;
                end else if (take_right || IS_HEAD) begin
                    // Last slot of the shifted run, or new key below the head
                    key_d   = new_key_i;
                    val_d   = new_val_i;
                    valid_d = 1'b1;
                end
            end
            default: begin
                // NOP holds the slot
                key_d   = key_q;
                val_d   = val_q;
                valid_d = valid_q;
            end
        endcase
    end

    // ----------------------------------------------------------------------
    // Slot registers
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_d;
        end
    end

    // Payload is meaningful only while valid
    always_ff @(posedge clk) begin
        key_q <= key_d;
        val_q <= val_d;
    end

    assign key_o        = key_q;
    assign val_o        = val_q;
    assign valid_o      = valid_q;
    assign ins_before_o = ins_before;
    assign take_right_o = take_right;

endmodule : pq_cell

`default_nettype wire

/* verilog/pq_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

// --------------------------------------------------------------------------
// Request decoder and occupancy tracking
// --------------------------------------------------------------------------

module pq_ctrl import pq_pkg::*; #(
    parameter int CAPACITY = 8
) (
    input  logic                             clk,
    input  logic                             reset_i,
    // Raw requests from the queue user
    input  logic                             enq_i,
    input  logic                             deq_i,
    // Operation broadcast to the cell chain
    output pq_op_e                           op_o,
    // Occupancy and flags, all registered
    output logic [$clog2(CAPACITY+1)-1:0]    count_o,
    output logic                             full_o,
    output logic                             empty_o
);

    localparam int CNT_W = $clog2(CAPACITY + 1);

    // Count register and the value it takes at the next edge
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] count_d;

    // Flags are kept as registers next to the count
    logic             full_q;
    logic             empty_q;

    // ----------------------------------------------------------------------
    // Decode
    // ----------------------------------------------------------------------

    // Only place where full and empty gate the requests
    always_comb begin
        op_o = PQ_NOP;
        if (enq_i && deq_i) begin
            // Both at once: nothing to remove when empty, so plain insert
            // Replace is allowed even when full since the head leaves
            op_o = empty_q ? PQ_ENQ : PQ_REPL;
        end else if (enq_i) begin
            // Enqueue on a full queue is dropped
            if (!full_q) begin
                op_o = PQ_ENQ;
            end
        end else if (deq_i) begin
            // Dequeue on an empty queue is dropped
            if (!empty_q) begin
                op_o = PQ_DEQ;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Occupancy
    // ----------------------------------------------------------------------

    // Replace removes one pair and adds one, so the count holds
    always_comb begin
        count_d = count_q;
        case (op_o)
            PQ_ENQ:  count_d = count_q + 1'b1;
            PQ_DEQ:  count_d = count_q - 1'b1;
            default: count_d = count_q;
        endcase
    end

    // Flags follow the next count so they line up with it after the edge
    always_ff @(posedge clk) begin
        if (reset_i) begin
            count_q <= '0;
            full_q  <= 1'b0;
            empty_q <= 1'b1;
        end else begin
            count_q <= count_d;
            full_q  <= (count_d == CNT_W'(CAPACITY));
            empty_q <= (count_d == '0);
        end
    end

    assign count_o = count_q;
    assign full_o  = full_q;
    assign empty_o = empty_q;

endmodule : pq_ctrl

`default_nettype wire

/* verilog/pq_pkg.sv */
`default_nettype none

// --------------------------------------------------------------------------
// Shared definitions for the sorted-array priority queue
// --------------------------------------------------------------------------

package pq_pkg;

    // Operation applied to every slot of the chain in one cycle
    // Decoded once in the controller, then broadcast to the cells
    typedef enum logic [1:0] {
        // Slots hold their contents
        PQ_NOP  = 2'b00,
        // Insert the new pair at its sorted position, tail shifts right
        PQ_ENQ  = 2'b01,
        // Drop the head, everything shifts one slot left
        PQ_DEQ  = 2'b10,
        // Drop the head and insert the new pair in the same cycle
        PQ_REPL = 2'b11
    } pq_op_e;

endpackage : pq_pkg

`default_nettype wire

/* verilog/quickq.sv */
`timescale 1ns/1ps
`default_nettype none

// --------------------------------------------------------------------------
// Priority queue top: controller plus a chain of sorted slots
// --------------------------------------------------------------------------

module quickq import pq_pkg::*; #(
    parameter int KEY_W    = 8,
    parameter int VAL_W    = 8,
    parameter int CAPACITY = 8
) (
    input  logic                             clk,
    input  logic                             reset_i,
    // Requests, new pair goes with enq_i
    input  logic                             enq_i,
    input  logic                             deq_i,
    input  logic [KEY_W-1:0]                 key_i,
    input  logic [VAL_W-1:0]                 val_i,
    // Head is slot 0, valid while empty_o is low
    output logic [KEY_W-1:0]                 head_key_o,
    output logic [VAL_W-1:0]                 head_val_o,
    output logic [$clog2(CAPACITY+1)-1:0]    count_o,
    output logic                             full_o,
    output logic                             empty_o
);

    localparam int CNT_W = $clog2(CAPACITY + 1);

    // Broadcast operation
    pq_op_e           op;
    logic [CNT_W-1:0] count;

    // Per-slot outputs, index 0 is the head
    logic [KEY_W-1:0] cell_key        [CAPACITY];
    logic [VAL_W-1:0] cell_val        [CAPACITY];
    logic             cell_valid      [CAPACITY];
    logic             cell_ins_before [CAPACITY];
    logic             cell_take_right [CAPACITY];

    pq_ctrl #(
        .CAPACITY (CAPACITY)
    ) i_pq_ctrl (
        .clk      (clk),
        .reset_i  (reset_i),
        .enq_i    (enq_i),
        .deq_i    (deq_i),
        .op_o     (op),
        .count_o  (count),
        .full_o   (full_o),
        .empty_o  (empty_o)
    );

    // ----------------------------------------------------------------------
    // Cell chain
    // ----------------------------------------------------------------------

    for (genvar i = 0; i < CAPACITY; i++) begin : g_cell
        logic [KEY_W-1:0] l_key;
        logic [VAL_W-1:0] l_val;
        logic             l_valid;
        logic             l_ins_before;
        logic [KEY_W-1:0] r_key;
        logic [VAL_W-1:0] r_val;
        logic             r_valid;
        logic             r_take_right;

        // Head has no left neighbor, never shifts in from the left
        if (i == 0) begin : g_left_end
            assign l_key        = '0;
            assign l_val        = '0;
            assign l_valid      = 1'b0;
            assign l_ins_before = 1'b0;
        end else begin : g_left
            assign l_key        = cell_key[i-1];
            assign l_val        = cell_val[i-1];
            assign l_valid      = cell_valid[i-1];
            assign l_ins_before = cell_ins_before[i-1];
        end

        // Tail pulls in an empty slot on dequeue
        if (i == CAPACITY - 1) begin : g_right_end
            assign r_key        = '0;
            assign r_val        = '0;
            assign r_valid      = 1'b0;
            assign r_take_right = 1'b0;
        end else begin : g_right
            assign r_key        = cell_key[i+1];
            assign r_val        = cell_val[i+1];
            assign r_valid      = cell_valid[i+1];
            assign r_take_right = cell_take_right[i+1];
        end

        pq_cell #(
            .KEY_W   (KEY_W),
            .VAL_W   (VAL_W),
            .IS_HEAD (i == 0)
        ) i_pq_cell (
            .clk                (clk),
            .reset_i            (reset_i),
            .op_i               (op),
            .new_key_i          (key_i),
            .new_val_i          (val_i),
            .left_key_i         (l_key),
            .left_val_i         (l_val),
            .left_valid_i       (l_valid),
            .left_ins_before_i  (l_ins_before),
            .right_key_i        (r_key),
            .right_val_i        (r_val),
            .right_valid_i      (r_valid),
            .right_take_right_i (r_take_right),
            .key_o              (cell_key[i]),
            .val_o              (cell_val[i]),
            .valid_o            (cell_valid[i]),
            .ins_before_o       (cell_ins_before[i]),
            .take_right_o       (cell_take_right[i])
        );
    end

    assign head_key_o = cell_key[0];
    assign head_val_o = cell_val[0];
    assign count_o    = count;

endmodule : quickq

`default_nettype wire
